// File: files.f
+incdir+.
vmul_pkg.sv
vmul_issue.sv
simd_mul.sv
vmul_writeback.sv
vmul_unit.sv
tb_clk_gen.sv
vmul_tb.sv

// File: run.sh
#!/bin/sh
# Build the vmul testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module vmul_tb -o vmul_sim \
  && out="$(./obj_dir/vmul_sim)"; echo "$out"; echo "$out" | grep -q "all tests passed" \
  && echo "simulation succeeded" && exit 0 \
  || { echo "simulation did not succeed"; exit 1; }

// File: vmul_model.svh
`ifndef VMUL_MODEL_SVH
`define VMUL_MODEL_SVH

// Lane value in 128 bits, sign or zero filled above the lane width
function automatic logic [127:0] widen_lane(input logic [63:0] v, input int bits,
                                            input bit sgn);
  logic [127:0] keep;
  logic [127:0] r;
  keep = (128'd1 << bits) - 128'd1;
  r    = {64'd0, v} & keep;
  if (sgn && v[bits-1]) begin
    r = r | ~keep;
  end
  return r;
endfunction

// Expected response of one request, worked out lane by lane
function automatic vmul_rsp_t expect_rsp(input vmul_req_t r);
  vmul_rsp_t    e;
  int           bits;
  logic [127:0] keep;
  logic [127:0] prod;
  logic [127:0] addend;
  logic [127:0] lane;
  logic [127:0] word;
  logic [63:0]  mcand;
  logic [63:0]  mplier;
  logic [63:0]  acc;
  bit           sgn_a;
  bit           sgn_b;
  bits  = 8 << r.vew;
  keep  = (128'd1 << bits) - 128'd1;
  word  = '0;
  // vs1 is always multiplied, VMADD and VNMSUB multiply vd and add vs2
  mcand = r.vs1;
  if (r.op == VMADD || r.op == VNMSUB) begin
    mplier = r.vd;
    acc    = r.vs2;
  end else begin
    mplier = r.vs2;
    acc    = r.vd;
  end
  // Signed a only for VMULH, signed b for VMULH and VMULHSU
  sgn_a = (r.op == VMULH);
  sgn_b = (r.op == VMULH) || (r.op == VMULHSU);
  for (int l = 0; l < 64 / bits; l++) begin
    // Full product, exact in its low 2*bits bits
    prod   = widen_lane(mcand >> (l * bits), bits, sgn_a)
           * widen_lane(mplier >> (l * bits), bits, sgn_b);
    addend = {64'd0, acc >> (l * bits)} & keep;
    case (r.op)
      VMUL:                   lane = prod;
      VMULH, VMULHU, VMULHSU: lane = prod >> bits;
      VMACC, VMADD:           lane = addend + prod;
      default:                lane = addend - prod;
    endcase
    // Wrap at the lane width and drop the lane into place
    word = word | ((lane & keep) << (l * bits));
  end
  e.result = word[63:0];
  e.mask   = r.mask;
  // Masked-off bytes read as all ones
  for (int i = 0; i < 8; i++) begin
    if (!r.mask[i]) begin
      e.result[8*i +: 8] = 8'hFF;
    end
  end
  return e;
endfunction

`endif

// File: vmul_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vmul_tb;

  import vmul_pkg::*;

  `include "vmul_model.svh"

  localparam int NumPipeRegs = 2;
  // Cycles from the handshake cycle to a visible response
  localparam int Latency     = NumPipeRegs + 2;
  localparam int ClkNs       = 4;
  localparam int DriveNs     = 1;
  localparam int ResetCycles = 5;
  // Request counts of the test phases
  localparam int NumHigh     = 4 * 4 * 8;
  localparam int NumAcc      = 4 * 4 * 8;
  localparam int NumMasked   = 200;
  localparam int NumStream   = 2000;
  localparam int NumReqs     = 1 + NumHigh + NumAcc + NumMasked + NumStream;
  localparam int TimeoutNs   = (NumReqs * Latency * 4 + 200) * ClkNs;
  localparam int unsigned Seed = 32'heff1_f368;

  logic        clk;
  logic        rst_n;
  vmul_req_t   req;
  logic        req_valid;
  logic        req_ready;
  vmul_rsp_t   rsp;
  logic        rsp_valid;
  logic        rsp_ready = 1'b1;

  // Expected responses in issue order
  vmul_rsp_t   exp_q[$];
  vmul_rsp_t   exp_rsp;
  int unsigned num_sent = 0;
  int unsigned num_recv = 0;
  // Rising edges since time zero
  int unsigned cycle = 0;
  // Random back-pressure on the response port when set
  bit          rand_ready = 1'b0;
  // Response stalled at the last falling edge
  bit          held = 1'b0;
  vmul_rsp_t   held_rsp;

  tb_clk_gen #(.PeriodNs(ClkNs)) u_clk_gen (.clk_o(clk));

  vmul_unit #(
    .NumPipeRegs (NumPipeRegs)
  ) u_vmul_unit (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .rsp_o       (rsp),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready)
  );

  task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
    $display("Fail at %0d ns: %s expected %h, got %h", $time, name, exp_val, act_val);
    $display("tests failed");
    $fatal;
  endtask

  task automatic abort_run(input string what);
    $display("%s, at %0d ns", what, $time);
    $display("tests failed");
    $fatal;
  endtask

  function automatic elen_t rand_word();
    return {$urandom, $urandom};
  endfunction

  function automatic vmul_req_t make_req(input vmul_op_e op, input vew_e vew, input strb_t mask);
    vmul_req_t r;
    r.op   = op;
    r.vew  = vew;
    r.vs1  = rand_word();
    r.vs2  = rand_word();
    r.vd   = rand_word();
    r.mask = mask;
    return r;
  endfunction

  // Offer one request and return just after the edge that takes it
  task automatic send_req(input vmul_req_t r);
    req       = r;
    req_valid = 1'b1;
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    @(posedge clk);
    #DriveNs;
    req_valid = 1'b0;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #DriveNs;
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Response back-pressure driven after the edge
  always @(posedge clk) begin
    #DriveNs;
    rsp_ready = rand_ready ? ($urandom_range(0, 1) == 1) : 1'b1;
  end

  // Scoreboard sampled at the falling edge where handshakes are settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (req_valid && req_ready) begin
        exp_q.push_back(expect_rsp(req));
        num_sent++;
      end
      // A stalled response holds valid and payload
      if (held) begin
        assert (rsp_valid) else abort_run("rsp_valid_o dropped while rsp_ready_i was low");
        assert (rsp.result == held_rsp.result)
          else report_mismatch("stalled rsp_o.result", held_rsp.result, rsp.result);
        assert (rsp.mask == held_rsp.mask)
          else report_mismatch("stalled rsp_o.mask", {56'd0, held_rsp.mask}, {56'd0, rsp.mask});
      end
      held     = rsp_valid && !rsp_ready;
      held_rsp = rsp;
      if (rsp_valid && rsp_ready) begin
        assert (exp_q.size() > 0) else abort_run("Response arrived with no request pending");
        exp_rsp = exp_q.pop_front();
        num_recv++;
        for (int i = 0; i < 8; i++) begin
          assert (rsp.mask[i] || rsp.result[8*i +: 8] == 8'hFF)
            else report_mismatch($sformatf("rsp_o.result byte %0d", i), 64'hFF,
                                 {56'd0, rsp.result[8*i +: 8]});
        end
        assert (rsp.result == exp_rsp.result)
          else report_mismatch("rsp_o.result", exp_rsp.result, rsp.result);
        assert (rsp.mask == exp_rsp.mask)
          else report_mismatch("rsp_o.mask", {56'd0, exp_rsp.mask}, {56'd0, rsp.mask});
      end
    end
  end

  // Watchdog
  initial begin
    #(TimeoutNs);
    abort_run("Timeout, responses stopped arriving");
  end

  initial begin
    int unsigned accept_cycle;
    vmul_req_t   r;
    void'($urandom(Seed));
    req       = '0;
    req_valid = 1'b0;
    rst_n     = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #DriveNs;
    rst_n = 1'b1;

    // Idle state after reset
    @(negedge clk);
    assert (!rsp_valid) else abort_run("rsp_valid_o is high after reset");
    assert (req_ready) else abort_run("req_ready_o is low after reset");
    idle_cycle();

    // Single request latency
    send_req(make_req(VMUL, EW32, 8'hFF));
    // Handshake cycle is the one just before the accepting edge
    accept_cycle = cycle - 1;
    @(negedge clk);
    while (!rsp_valid) @(negedge clk);
    assert (cycle - accept_cycle == Latency)
      else report_mismatch("rsp_valid_o latency", 64'(Latency), 64'(cycle - accept_cycle));
    idle_cycle();

    // Low and high half products at every width
    for (int o = 0; o < 4; o++) begin
      for (int w = 0; w < 4; w++) begin
        repeat (8) send_req(make_req(vmul_op_e'(o), vew_e'(w), 8'hFF));
      end
    end

    // Accumulate forms with the operand roles told apart
    for (int o = 4; o < 8; o++) begin
      for (int w = 0; w < 4; w++) begin
        repeat (8) begin
          r = make_req(vmul_op_e'(o), vew_e'(w), 8'hFF);
          // Even vs1 lanes and odd vd-vs2 lanes make both role maps differ in every lane
          r.vs1 = r.vs1 & 64'hFEFE_FEFE_FEFE_FEFE;
          r.vs2 = r.vd ^ 64'h0101_0101_0101_0101;
          send_req(r);
        end
      end
    end

    // Random masks
    repeat (NumMasked) begin
      send_req(make_req(vmul_op_e'($urandom_range(0, 7)), vew_e'($urandom_range(0, 3)),
                        strb_t'($urandom)));
    end

    // Long stream with gaps and back-pressure
    rand_ready = 1'b1;
    repeat (NumStream) begin
      if ($urandom_range(0, 2) == 0) begin
        idle_cycle();
      end
      send_req(make_req(vmul_op_e'($urandom_range(0, 7)), vew_e'($urandom_range(0, 3)),
                        strb_t'($urandom)));
    end

    // Drain and then watch for stray responses
    while (exp_q.size() != 0) @(posedge clk);
    repeat (Latency + 2) @(posedge clk);
    if (num_sent == NumReqs && num_recv == num_sent) begin
      $display("all tests passed");
      $finish;
    end else begin
      abort_run("Response count does not match request count");
    end
  end

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  // Clock period in ns
  parameter real PeriodNs = 4.0
) (
  output logic clk_o
);

  // Free running clock, low at time zero
  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2.0) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// File: vmul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module vmul_unit #(
  // Pipeline registers inside the multiplier
  parameter int NumPipeRegs = 1
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Request port
  input  vmul_pkg::vmul_req_t req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  // Response port
  output vmul_pkg::vmul_rsp_t rsp_o,
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i
);

  import vmul_pkg::*;

  // Issue to multiplier link
  mul_op_t   mul_op;
  logic      mul_valid;
  logic      mul_ready;

  // Multiplier to writeback link
  vmul_rsp_t mul_rsp;
  logic      mul_rsp_valid;
  logic      mul_rsp_ready;

  // Register request and assign operand roles
  vmul_issue u_issue (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .mul_o       (mul_op),
    .mul_valid_o (mul_valid),
    .mul_ready_i (mul_ready)
  );

  // Lane arithmetic, NumPipeRegs cycles deep
  simd_mul #(
    .NumPipeRegs (NumPipeRegs)
  ) u_mul (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .mul_i   (mul_op),
    .valid_i (mul_valid),
    .ready_o (mul_ready),
    .rsp_o   (mul_rsp),
    .valid_o (mul_rsp_valid),
    .ready_i (mul_rsp_ready)
  );

  // Mask fill and output register
  vmul_writeback u_writeback (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .rsp_i   (mul_rsp),
    .valid_i (mul_rsp_valid),
    .ready_o (mul_rsp_ready),
    .rsp_o   (rsp_o),
    .valid_o (rsp_valid_o),
    .ready_i (rsp_ready_i)
  );

endmodule

`default_nettype wire

// File: vmul_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module vmul_writeback (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // From the multiplier
  input  vmul_pkg::vmul_rsp_t rsp_i,
  input  logic                valid_i,
  output logic                ready_o,
  // Toward the outside
  output vmul_pkg::vmul_rsp_t rsp_o,
  output logic                valid_o,
  input  logic                ready_i
);

  import vmul_pkg::*;

  // Masked response, before the register
  vmul_rsp_t rsp_d;
  // One-deep output register
  vmul_rsp_t rsp_q;
  logic      valid_q;

  // Mask-agnostic fill
  // inactive bytes are written as all ones
  always_comb begin
    rsp_d.mask = rsp_i.mask;
    for (int b = 0; b < StrbBits; b++) begin
      rsp_d.result[8*b +: 8] = rsp_i.mask[b] ? rsp_i.result[8*b +: 8] : 8'hFF;
    end
  end

  // Ready when empty or when the outside takes the held response
  assign ready_o = ~valid_q | ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Response payload, loaded on each transfer in
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_o   = rsp_q;
  assign valid_o = valid_q;

endmodule

`default_nettype wire

// File: simd_mul.sv
`timescale 1ns/1ps
`default_nettype none

module simd_mul #(
  // Internal pipeline depth, zero gives a combinational path
  parameter int NumPipeRegs = 0
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Operand side
  input  vmul_pkg::mul_op_t   mul_i,
  input  logic                valid_i,
  output logic                ready_o,
  // Result side
  output vmul_pkg::vmul_rsp_t rsp_o,
  output logic                valid_o,
  input  logic                ready_i
);

  import vmul_pkg::*;

  // Stage inputs
  // index i feeds register i and the last index feeds the multiplier
  mul_op_t [NumPipeRegs:0] stage_d;
  logic    [NumPipeRegs:0] valid_d;
  // Ready runs backward combinationally through all stages
  logic    [NumPipeRegs:0] stage_ready;

  // Operands seen by the arithmetic
  mul_op_t mul_s;
  // Per-width results, one word for each element width
  elen_t [3:0] res_by_ew;
  // Signedness of the two multiplicands
  logic signed_a;
  logic signed_b;

  // Head of the pipeline comes from the ports
  assign stage_d[0] = mul_i;
  assign valid_d[0] = valid_i;

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    mul_op_t stage_q;
    logic    valid_q;

    // Advance when the next stage takes our item or we hold a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~valid_q;

    // Valid chain
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        valid_q <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q <= valid_d[i];
      end
    end

    // Operands, op, width and mask
    always_ff @(posedge clk_i) begin
      if (stage_ready[i]) begin
        stage_q <= stage_d[i];
      end
    end

    // Feed the next stage
    assign stage_d[i+1] = stage_q;
    assign valid_d[i+1] = valid_q;
  end

  // Tail of the pipeline
  assign stage_ready[NumPipeRegs] = ready_i;
  assign ready_o                  = stage_ready[0];
  assign mul_s                    = stage_d[NumPipeRegs];
  assign valid_o                  = valid_d[NumPipeRegs];

  // Sign select
  // only VMULH treats a as signed
  assign signed_a = (mul_s.op == VMULH);
  // b is signed for VMULH and VMULHSU
  assign signed_b = mul_s.op inside {VMULH, VMULHSU};

  // One lane array per element width
  for (genvar w = 0; w < 4; w++) begin : gen_ew
    localparam int unsigned EW       = 8 << w;
    localparam int unsigned NumLanes = ElenBits / EW;

    // Word assembled from the lanes of this width
    elen_t ew_res;

    for (genvar l = 0; l < NumLanes; l++) begin : gen_lane
      logic        [EW-1:0]   a_lane;
      logic        [EW-1:0]   b_lane;
      logic        [EW-1:0]   c_lane;
      logic signed [EW:0]     a_ext;
      logic signed [EW:0]     b_ext;
      // Double-width product with room for the sign bits
      logic signed [2*EW+1:0] prod;
      logic        [EW-1:0]   lane_res;

      // Slice the lane out of each operand
      assign a_lane = mul_s.opa[l*EW +: EW];
      assign b_lane = mul_s.opb[l*EW +: EW];
      assign c_lane = mul_s.opc[l*EW +: EW];

      // Extend by one bit, sign or zero as the op asks
      assign a_ext = $signed({a_lane[EW-1] & signed_a, a_lane});
      assign b_ext = $signed({b_lane[EW-1] & signed_b, b_lane});

      assign prod = a_ext * b_ext;

      // Result select
      always_comb begin
        unique case (mul_s.op)
          // Low half
          VMUL: lane_res = prod[EW-1:0];
          // High half for all three sign variants
          VMULH, VMULHU, VMULHSU: lane_res = prod[2*EW-1:EW];
          // Add low half to the addend, wraps at lane width
          VMACC, VMADD: lane_res = c_lane + prod[EW-1:0];
          // Subtract low half from the addend
          VNMSAC, VNMSUB: lane_res = c_lane - prod[EW-1:0];
          default: lane_res = '0;
        endcase
      end

      assign ew_res[l*EW +: EW] = lane_res;
    end

    assign res_by_ew[w] = ew_res;
  end

  // Width select by the runtime element width
  assign rsp_o.result = res_by_ew[mul_s.vew];
  // Mask travels untouched
  assign rsp_o.mask   = mul_s.mask;

endmodule

`default_nettype wire

// File: vmul_issue.sv
`timescale 1ns/1ps
`default_nettype none

module vmul_issue (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Request side
  input  vmul_pkg::vmul_req_t req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  // Multiplier side
  output vmul_pkg::mul_op_t   mul_o,
  output logic                mul_valid_o,
  input  logic                mul_ready_i
);

  import vmul_pkg::*;

  // Operands after role mapping, before the register
  mul_op_t mul_d;
  // One-deep output register
  mul_op_t mul_q;
  logic    valid_q;

  // Role assignment
  always_comb begin
    mul_d.op   = req_i.op;
    mul_d.vew  = req_i.vew;
    mul_d.mask = req_i.mask;
    // Multiplicand a is always vs1
    mul_d.opa  = req_i.vs1;
    if (req_i.op inside {VMADD, VNMSUB}) begin
      // vd becomes the multiplicand and vs2 the addend
      // so the multiplier treats these like VMACC and VNMSAC
      mul_d.opb = req_i.vd;
      mul_d.opc = req_i.vs2;
    end else begin
      // Plain multiply and accumulate forms
      mul_d.opb = req_i.vs2;
      mul_d.opc = req_i.vd;
    end
  end

  // Ready when empty or when the multiplier takes the held item
  assign req_ready_o = ~valid_q | mul_ready_i;

  // Valid flag of the stage
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (req_ready_o) begin
      // Load a new item or become empty
      valid_q <= req_valid_i;
    end
  end

  // Payload only moves on an accepted request
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      mul_q <= mul_d;
    end
  end

  // Drive the multiplier
  assign mul_o       = mul_q;
  assign mul_valid_o = valid_q;

endmodule

`default_nettype wire

// File: vmul_pkg.sv
`default_nettype none

package vmul_pkg;

  // Datapath width of one lane word
  localparam int unsigned ElenBits = 64;
  // One strobe bit per byte of the word
  localparam int unsigned StrbBits = ElenBits / 8;

  // One packed word of elements
  typedef logic [ElenBits-1:0] elen_t;
  // Byte mask of a word
  typedef logic [StrbBits-1:0] strb_t;

  // Element width selected per request
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Supported integer multiply operations
  typedef enum logic [2:0] {
    VMUL    = 3'd0,
    VMULH   = 3'd1,
    VMULHU  = 3'd2,
    VMULHSU = 3'd3,
    VMACC   = 3'd4,
    VNMSAC  = 3'd5,
    VMADD   = 3'd6,
    VNMSUB  = 3'd7
  } vmul_op_e;

  // Request as it enters the lane
  typedef struct packed {
    vmul_op_e op;
    vew_e     vew;
    elen_t    vs1;
    elen_t    vs2;
    elen_t    vd;
    strb_t    mask;
  } vmul_req_t;

  // Request after operand role assignment
  // opa and opb are multiplied and opc is the addend
  typedef struct packed {
    vmul_op_e op;
    vew_e     vew;
    elen_t    opa;
    elen_t    opb;
    elen_t    opc;
    strb_t    mask;
  } mul_op_t;

  // Response word with its byte mask
  typedef struct packed {
    elen_t result;
    strb_t mask;
  } vmul_rsp_t;

endpackage

`default_nettype wire
